/* source/vpu_pkg.sv */
package vpu_pkg;

    localparam int lanes          = 16;
    localparam int lane_width     = 32;
    localparam int vec_width      = lanes * lane_width; // 512
    localparam int reg_count      = 32;
    localparam int reg_addr_width = 5;
    localparam int frac_bits      = 16;                 // Q16.16

    // codes 8..15 are unused and behave as nop
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_mul   = 4'd3,
        op_mac   = 4'd4,
        op_max   = 4'd5,
        op_shr   = 4'd6,
        op_splat = 4'd7
    } vpu_op_e;

    typedef enum logic [2:0] {
        fn_add  = 3'd0,
        fn_sub  = 3'd1,
        fn_mul  = 3'd2,
        fn_mac  = 3'd3,
        fn_max  = 3'd4,
        fn_shr  = 3'd5,
        fn_pass = 3'd6  // splat passes operand b
    } lane_fn_e;

    typedef logic [reg_count-1:0][vec_width-1:0] vrf_image_t;

    // filter constants in Q16.16
    localparam logic [lane_width-1:0] q_one     = 32'h0001_0000;
    localparam logic [lane_width-1:0] q_step    = 32'h0000_0148; // 0.005
    localparam logic [lane_width-1:0] q_gravity = 32'h0009_CF5C; // 9.81

    // 0.5 * step^2 rounded to nearest
    localparam logic [lane_width-1:0] q_half_step_sq =
        32'(((64'(q_step) * 64'(q_step)) + (64'd1 << frac_bits)) >> (frac_bits + 1));

    function automatic vrf_image_t build_reset_image();
        vrf_image_t img;
        img = '0;
        for (int i = 0; i < lanes; i++) begin
            img[1][i*lane_width +: lane_width] = q_one;
            img[2][i*lane_width +: lane_width] = 32'(i) << frac_bits; // lane index
            img[3][i*lane_width +: lane_width] = q_step;
            img[4][i*lane_width +: lane_width] = q_half_step_sq;
        end
        img[5][lane_width-1:0] = q_gravity; // lane 0 only
        return img;
    endfunction

    localparam vrf_image_t vrf_reset_image = build_reset_image();

endpackage

/* source/vpu_ifs.sv */
// decoded lane controls from decode to execute
interface vec_op_if;

    logic                                  valid;
    vpu_pkg::lane_fn_e                     fn;
    logic [vpu_pkg::reg_addr_width-1:0]    dst;
    logic [vpu_pkg::reg_addr_width-1:0]    src_a;
    logic [vpu_pkg::reg_addr_width-1:0]    src_b;
    logic [vpu_pkg::reg_addr_width-1:0]    src_c;
    logic [vpu_pkg::lane_width-1:0]        imm;
    logic                                  use_imm; // imm replaces operand b

    modport source (
        output valid, fn, dst, src_a, src_b, src_c, imm, use_imm
    );

    modport sink (
        input valid, fn, dst, src_a, src_b, src_c, imm, use_imm
    );

endinterface

// execute result for the write port and the result outputs
interface vec_wb_if;

    logic                               valid; // also the write enable
    logic [vpu_pkg::reg_addr_width-1:0] dst;
    logic [vpu_pkg::vec_width-1:0]      data;

    modport source (
        output valid, dst, data
    );

    modport sink (
        input valid, dst, data
    );

endinterface

/* source/vpu_lane_alu.sv */
module vpu_lane_alu (
    input  vpu_pkg::lane_fn_e                     fn,
    input  logic signed [vpu_pkg::lane_width-1:0] a,
    input  logic signed [vpu_pkg::lane_width-1:0] b,
    input  logic signed [vpu_pkg::lane_width-1:0] c,
    output logic        [vpu_pkg::lane_width-1:0] y
);

    logic signed [2*vpu_pkg::lane_width-1:0] product;
    logic signed [vpu_pkg::lane_width-1:0]   mul_q;

    // full signed product, then drop the extra fraction bits
    assign product = a * b;
    assign mul_q   = product[vpu_pkg::frac_bits +: vpu_pkg::lane_width]; // bits 47:16

    always_comb begin
        case (fn)
            vpu_pkg::fn_add: begin
                y = a + b;             // wraps at 32 bits
            end
            vpu_pkg::fn_sub: begin
                y = a - b;
            end
            vpu_pkg::fn_mul: begin
                y = mul_q;
            end
            vpu_pkg::fn_mac: begin
                y = mul_q + c;         // accumulate into c
            end
            vpu_pkg::fn_max: begin
                y = (a > b) ? a : b;   // signed compare
            end
            vpu_pkg::fn_shr: begin
                y = a >>> b[4:0];      // sign fills from the top
            end
            vpu_pkg::fn_pass: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

/* source/vpu_decode.sv */
module vpu_decode (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               issue,
    input  vpu_pkg::vpu_op_e                   op,
    input  logic [vpu_pkg::reg_addr_width-1:0] dst,
    input  logic [vpu_pkg::reg_addr_width-1:0] src_a,
    input  logic [vpu_pkg::reg_addr_width-1:0] src_b,
    input  logic [vpu_pkg::reg_addr_width-1:0] src_c,
    input  logic [vpu_pkg::lane_width-1:0]     imm,
    vec_op_if.source                           ctl
);

    vpu_pkg::lane_fn_e fn_next;
    logic              use_imm_next;
    logic              known;      // opcode produces a result

    always_comb begin
        fn_next      = vpu_pkg::fn_add;
        use_imm_next = 1'b0;
        known        = 1'b1;
        case (op)
            vpu_pkg::op_add:   fn_next = vpu_pkg::fn_add;
            vpu_pkg::op_sub:   fn_next = vpu_pkg::fn_sub;
            vpu_pkg::op_mul:   fn_next = vpu_pkg::fn_mul;
            vpu_pkg::op_mac:   fn_next = vpu_pkg::fn_mac;
            vpu_pkg::op_max:   fn_next = vpu_pkg::fn_max;
            vpu_pkg::op_shr: begin
                fn_next      = vpu_pkg::fn_shr;
                use_imm_next = 1'b1;   // shift amount from imm
            end
            vpu_pkg::op_splat: begin
                fn_next      = vpu_pkg::fn_pass;
                use_imm_next = 1'b1;
            end
            default:           known = 1'b0; // nop and unused codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctl.valid <= 1'b0;
        end else begin
            ctl.valid <= issue && known; // nop and unused codes stop here
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        ctl.fn      <= fn_next;
        ctl.use_imm <= use_imm_next;
        ctl.dst     <= dst;
        ctl.src_a   <= src_a;
        ctl.src_b   <= src_b;
        ctl.src_c   <= src_c;
        ctl.imm     <= imm;
    end

endmodule

/* source/vpu_vrf.sv */
module vpu_vrf (
    input  logic                               clk,
    input  logic                               rst_n,
    vec_wb_if.sink                             wr,
    input  logic [vpu_pkg::reg_addr_width-1:0] addr_a,
    input  logic [vpu_pkg::reg_addr_width-1:0] addr_b,
    input  logic [vpu_pkg::reg_addr_width-1:0] addr_c,
    output logic [vpu_pkg::vec_width-1:0]      data_a,
    output logic [vpu_pkg::vec_width-1:0]      data_b,
    output logic [vpu_pkg::vec_width-1:0]      data_c
);

    logic [vpu_pkg::vec_width-1:0] vectors [vpu_pkg::reg_count];

    logic hit_a;
    logic hit_b;
    logic hit_c;

    // write in flight to the same register
    assign hit_a = wr.valid && (wr.dst == addr_a);
    assign hit_b = wr.valid && (wr.dst == addr_b);
    assign hit_c = wr.valid && (wr.dst == addr_c);

    // a dependent instruction sees the new value
    // without waiting for the commit edge
    assign data_a = hit_a ? wr.data : vectors[addr_a];
    assign data_b = hit_b ? wr.data : vectors[addr_b];
    assign data_c = hit_c ? wr.data : vectors[addr_c];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < vpu_pkg::reg_count; i++) begin
                vectors[i] <= vpu_pkg::vrf_reset_image[i]; // constant table
            end
        end else if (wr.valid) begin
            vectors[wr.dst] <= wr.data;
        end
    end

endmodule

/* source/vpu_execute.sv */
module vpu_execute (
    input  logic                               clk,
    input  logic                               rst_n,
    vec_op_if.sink                             ctl,
    input  logic [vpu_pkg::vec_width-1:0]      data_a,
    input  logic [vpu_pkg::vec_width-1:0]      data_b,
    input  logic [vpu_pkg::vec_width-1:0]      data_c,
    output logic [vpu_pkg::reg_addr_width-1:0] addr_a,
    output logic [vpu_pkg::reg_addr_width-1:0] addr_b,
    output logic [vpu_pkg::reg_addr_width-1:0] addr_c,
    vec_wb_if.source                           wb
);

    logic [vpu_pkg::vec_width-1:0] result; // all lanes joined

    // operand reads go straight out, data comes back this cycle
    assign addr_a = ctl.src_a;
    assign addr_b = ctl.src_b;
    assign addr_c = ctl.src_c;

    for (genvar i = 0; i < vpu_pkg::lanes; i++) begin : g_lane
        logic signed [vpu_pkg::lane_width-1:0] lane_a;
        logic signed [vpu_pkg::lane_width-1:0] lane_b;
        logic signed [vpu_pkg::lane_width-1:0] lane_c;
        logic        [vpu_pkg::lane_width-1:0] lane_y;

        assign lane_a = data_a[i*vpu_pkg::lane_width +: vpu_pkg::lane_width];
        assign lane_c = data_c[i*vpu_pkg::lane_width +: vpu_pkg::lane_width];

        // shift and splat take the immediate
        assign lane_b = ctl.use_imm ? ctl.imm
                                    : data_b[i*vpu_pkg::lane_width +: vpu_pkg::lane_width];

        vpu_lane_alu lane_alu_i (
            .fn (ctl.fn),
            .a  (lane_a),
            .b  (lane_b),
            .c  (lane_c),
            .y  (lane_y)
        );

        assign result[i*vpu_pkg::lane_width +: vpu_pkg::lane_width] = lane_y;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ctl.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.dst  <= ctl.dst;
        wb.data <= result;
    end

endmodule

/* source/vpu_top.sv */
module vpu_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               issue,
    input  vpu_pkg::vpu_op_e                   op,
    input  logic [vpu_pkg::reg_addr_width-1:0] dst,
    input  logic [vpu_pkg::reg_addr_width-1:0] src_a,
    input  logic [vpu_pkg::reg_addr_width-1:0] src_b,
    input  logic [vpu_pkg::reg_addr_width-1:0] src_c,
    input  logic [vpu_pkg::lane_width-1:0]     imm,
    output logic                               result_valid,
    output logic [vpu_pkg::reg_addr_width-1:0] result_dst,
    output logic [vpu_pkg::vec_width-1:0]      result_data
);

    vec_op_if ctl_if ();
    vec_wb_if wb_if ();

    logic [vpu_pkg::reg_addr_width-1:0] rd_addr_a;
    logic [vpu_pkg::reg_addr_width-1:0] rd_addr_b;
    logic [vpu_pkg::reg_addr_width-1:0] rd_addr_c;
    logic [vpu_pkg::vec_width-1:0]      rd_data_a;
    logic [vpu_pkg::vec_width-1:0]      rd_data_b;
    logic [vpu_pkg::vec_width-1:0]      rd_data_c;

    vpu_decode decode_i (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .op    (op),
        .dst   (dst),
        .src_a (src_a),
        .src_b (src_b),
        .src_c (src_c),
        .imm   (imm),
        .ctl   (ctl_if.source)
    );

    vpu_execute execute_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctl    (ctl_if.sink),
        .data_a (rd_data_a),
        .data_b (rd_data_b),
        .data_c (rd_data_c),
        .addr_a (rd_addr_a),
        .addr_b (rd_addr_b),
        .addr_c (rd_addr_c),
        .wb     (wb_if.source)
    );

    vpu_vrf vrf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wb_if.sink),
        .addr_a (rd_addr_a),
        .addr_b (rd_addr_b),
        .addr_c (rd_addr_c),
        .data_a (rd_data_a),
        .data_b (rd_data_b),
        .data_c (rd_data_c)
    );

    // writeback is visible outside in the same cycle it is written
    assign result_valid = wb_if.valid;
    assign result_dst   = wb_if.dst;
    assign result_data  = wb_if.data;

endmodule

/* tests/vpu_tb_util.svh */
`ifndef VPU_TB_UTIL_SVH
`define VPU_TB_UTIL_SVH

// galois taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] draw_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state); // one step per bit
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// expected Q16.16 lane result from the lane rules
function automatic logic [31:0] ref_lane(vpu_pkg::vpu_op_e code, logic [31:0] a,
                                         logic [31:0] b, logic [31:0] c);
    logic [63:0] prod;
    logic [31:0] q;
    prod = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // sign extension keeps the low 64 bits exact
    q    = prod[47:16];
    case (code)
        vpu_pkg::op_add: return a + b;
        vpu_pkg::op_sub: return a - b;
        vpu_pkg::op_mul: return q;
        vpu_pkg::op_mac: return q + c;
        vpu_pkg::op_max: return ($signed(a) >= $signed(b)) ? a : b;
        vpu_pkg::op_shr: return 32'($signed(a) >>> b[4:0]);
        default:         return b; // splat
    endcase
endfunction

// drive one instruction and update the model in issue order
task automatic issue_op(vpu_pkg::vpu_op_e code, logic [4:0] d, logic [4:0] a,
                        logic [4:0] b, logic [4:0] c, logic [31:0] value);
    exp_t        e;
    logic [31:0] opb;
    issue = 1'b1;
    op    = code;
    dst   = d;
    src_a = a;
    src_b = b;
    src_c = c;
    imm   = value;
    if (code != vpu_pkg::op_nop && code <= vpu_pkg::op_splat) begin
        for (int i = 0; i < 16; i++) begin
            opb = (code == vpu_pkg::op_shr || code == vpu_pkg::op_splat)
                ? value : model[b][i*32 +: 32];
            e.data[i*32 +: 32] = ref_lane(code, model[a][i*32 +: 32], opb,
                                          model[c][i*32 +: 32]);
        end
        e.dst    = d;
        e.cycle  = cycle_count;
        model[d] = e.data;
        exp_q.push_back(e);
    end
    @(posedge clk);
    #drive_delay;
    issue = 1'b0;
endtask

`endif

/* tests/vpu_tb.sv */
module vpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int drive_delay = 10;
    localparam int reset_cycles = 3;
    // issue and drain cycles of each test
    localparam int test_cycles = 15 + 45 + 15 + 12 + 20 + 25;
    localparam int max_cycles = reset_cycles + test_cycles + 50;

    typedef struct packed {
        logic [4:0]   dst;
        logic [511:0] data;
        int           cycle; // cycle of the issue drive
    } exp_t;

    logic                   clk;
    logic                   rst_n;
    logic                   issue;
    vpu_pkg::vpu_op_e       op;
    logic [4:0]             dst;
    logic [4:0]             src_a;
    logic [4:0]             src_b;
    logic [4:0]             src_c;
    logic [31:0]            imm;
    logic                   result_valid;
    logic [4:0]             result_dst;
    logic [511:0]           result_data;

    logic [511:0]           model [32];
    exp_t                   exp_q [$];
    logic [31:0]            lfsr_state = 32'h3041;
    int                     cycle_count = 0;
    int                     pass_count = 0;
    int                     fail_count = 0;
    int                     passes_at_start = 0;
    int                     fails_at_start = 0;
    string                  test_name = "reset";
    vpu_pkg::vpu_op_e       arith_ops [5] = '{vpu_pkg::op_add, vpu_pkg::op_sub,
                                              vpu_pkg::op_mul, vpu_pkg::op_max,
                                              vpu_pkg::op_shr};

    `include "vpu_tb_util.svh"

    vpu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .op           (op),
        .dst          (dst),
        .src_a        (src_a),
        .src_b        (src_b),
        .src_c        (src_c),
        .imm          (imm),
        .result_valid (result_valid),
        .result_dst   (result_dst),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run went past %0d cycles in test %s", max_cycles, test_name);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(string what, logic [511:0] expected, logic [511:0] actual);
        fail_count++;
        $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_error(string msg);
        fail_count++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !result_valid)
        else report_error("result_valid high in the cycle after reset");

    // outputs are stable by the falling edge
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].cycle + 2 == cycle_count) begin
            assert (result_valid === 1'b1)
                else report_error("result_valid missing two cycles after issue");
            if (result_valid === 1'b1) begin
                assert (result_dst == exp_q[0].dst)
                    else report_mismatch("dst", 512'(exp_q[0].dst), 512'(result_dst));
                assert (result_data == exp_q[0].data)
                    else report_mismatch("data", exp_q[0].data, result_data);
                if (result_dst == exp_q[0].dst && result_data == exp_q[0].data) begin
                    pass_count++;
                end
            end
            void'(exp_q.pop_front());
        end else begin
            assert (result_valid === 1'b0)
                else report_error("result_valid high with no valid issue two cycles before");
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        exp_q.delete(); // in-flight work is lost
        for (int r = 0; r < 32; r++) begin
            model[r] = vpu_pkg::vrf_reset_image[r];
        end
        repeat (reset_cycles) begin
            @(posedge clk);
            #drive_delay;
            issue = 1'b0;
        end
        rst_n = 1'b1;
    endtask

    task automatic start_test(string name);
        test_name       = name;
        passes_at_start = pass_count;
        fails_at_start  = fail_count;
    endtask

    task automatic drain_results();
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    task automatic finish_test();
        drain_results();
        repeat (2) begin // room for a stray strobe
            @(posedge clk);
            #drive_delay;
        end
        $display("test %-16s results %0d, errors %0d", test_name,
                 pass_count - passes_at_start, fail_count - fails_at_start);
    endtask

    // copy a register to scratch v30 through an add with zero
    task automatic read_reg(logic [4:0] r);
        issue_op(vpu_pkg::op_add, 5'd30, r, 5'd24, 5'd0, 32'd0);
    endtask

    initial begin
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] value;
        rst_n = 1'b0;
        issue = 1'b0;
        op    = vpu_pkg::op_nop;
        dst   = '0;
        src_a = '0;
        src_b = '0;
        src_c = '0;
        imm   = '0;
        #drive_delay;
        apply_reset();

        start_test("reset_image");
        for (int r = 1; r <= 5; r++) begin
            issue_op(vpu_pkg::op_add, 5'(25 + r), 5'(r), 5'd24, 5'd0, 32'd0);
        end
        finish_test();

        start_test("lane_arith");
        issue_op(vpu_pkg::op_splat, 5'd8, 5'd0, 5'd0, 5'd0, 32'h7FFF_FFFF);
        issue_op(vpu_pkg::op_splat, 5'd9, 5'd0, 5'd0, 5'd0, 32'h0000_0001);
        issue_op(vpu_pkg::op_splat, 5'd10, 5'd0, 5'd0, 5'd0, 32'hFFFE_8000); // -1.5
        issue_op(vpu_pkg::op_splat, 5'd11, 5'd0, 5'd0, 5'd0, 32'h0002_4000); // 2.25
        issue_op(vpu_pkg::op_add, 5'd12, 5'd8, 5'd9, 5'd0, 32'd0);          // wraps
        issue_op(vpu_pkg::op_mul, 5'd13, 5'd10, 5'd11, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_shr, 5'd14, 5'd10, 5'd0, 5'd0, 32'd3);
        for (int k = 0; k < 6; k++) begin
            rd    = 5'(8 + draw_bits(4));
            value = draw_bits(32);
            issue_op(vpu_pkg::op_splat, rd, 5'd0, 5'd0, 5'd0, value);
        end
        for (int k = 0; k < 20; k++) begin
            rd    = 5'(8 + draw_bits(4));
            ra    = 5'(8 + draw_bits(4));
            rb    = 5'(8 + draw_bits(4));
            value = draw_bits(5);
            issue_op(arith_ops[k % 5], rd, ra, rb, 5'd0, value);
        end
        finish_test();

        start_test("dependent_chain");
        issue_op(vpu_pkg::op_splat, 5'd16, 5'd0, 5'd0, 5'd0, 32'h0001_8000);
        issue_op(vpu_pkg::op_add, 5'd16, 5'd16, 5'd2, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_mul, 5'd17, 5'd16, 5'd16, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_sub, 5'd17, 5'd17, 5'd1, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_max, 5'd18, 5'd17, 5'd16, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_shr, 5'd18, 5'd18, 5'd0, 5'd0, 32'd2);
        issue_op(vpu_pkg::op_mac, 5'd19, 5'd18, 5'd3, 5'd18, 32'd0);
        issue_op(vpu_pkg::op_add, 5'd19, 5'd19, 5'd19, 5'd0, 32'd0);
        finish_test();

        start_test("mac_three_ports");
        issue_op(vpu_pkg::op_splat, 5'd20, 5'd0, 5'd0, 5'd0, 32'h0003_0000);
        issue_op(vpu_pkg::op_splat, 5'd21, 5'd0, 5'd0, 5'd0, 32'hFFFF_C000); // -0.25
        issue_op(vpu_pkg::op_mac, 5'd22, 5'd20, 5'd21, 5'd2, 32'd0);
        issue_op(vpu_pkg::op_mac, 5'd22, 5'd22, 5'd22, 5'd22, 32'd0);
        finish_test();

        start_test("latency_drop");
        issue_op(vpu_pkg::op_add, 5'd8, 5'd1, 5'd2, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_nop, 5'd9, 5'd1, 5'd1, 5'd0, 32'd0);
        issue_op(vpu_pkg::vpu_op_e'(4'd9), 5'd10, 5'd1, 5'd1, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_sub, 5'd11, 5'd2, 5'd1, 5'd0, 32'd0);
        issue_op(vpu_pkg::vpu_op_e'(4'd15), 5'd12, 5'd5, 5'd5, 5'd0, 32'd0);
        issue_op(vpu_pkg::op_nop, 5'd8, 5'd0, 5'd0, 5'd0, 32'd0);
        for (int r = 8; r <= 12; r++) begin
            read_reg(5'(r));
        end
        finish_test();

        start_test("reset_mid_run");
        for (int r = 1; r <= 5; r++) begin
            issue_op(vpu_pkg::op_splat, 5'(r), 5'd0, 5'd0, 5'd0, 32'h1234_5600 + 32'(r));
        end
        drain_results(); // image registers now hold other values
        issue_op(vpu_pkg::op_splat, 5'd1, 5'd0, 5'd0, 5'd0, 32'h1234_5678);
        issue = 1'b1; // second one goes in with the reset
        op    = vpu_pkg::op_add;
        dst   = 5'd2;
        src_a = 5'd1;
        src_b = 5'd1;
        apply_reset();
        for (int r = 1; r <= 5; r++) begin
            read_reg(5'(r));
        end
        finish_test();

        $display("results checked %0d, errors %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+tests
source/vpu_pkg.sv
source/vpu_ifs.sv
source/vpu_lane_alu.sv
source/vpu_decode.sv
source/vpu_vrf.sv
source/vpu_execute.sv
source/vpu_top.sv
tests/vpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := vpu_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FLIST)) tests/vpu_tb_util.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "run incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
